// ==== fp_pkg.sv ====
package fp_pkg;

	localparam int EXP_W    = 8;
	localparam int MAN_W    = 23;
	localparam int SIG_W    = MAN_W + 1;  // hidden one included
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 254;        // largest normal biased exponent

	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] frac;
	} fp_word_t;

	typedef logic [SIG_W-1:0] sig_t;

endpackage

// ==== alu_pkg.sv ====
package alu_pkg;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MUL,
		OP_DIV
	} alu_op_e;

	typedef struct packed {
		logic ovf;
		logic unf;
		logic dbz;  // divisor is zero
		logic zbz;  // zero divided by zero
	} alu_flags_t;

	typedef struct packed {
		logic gt;
		logic eq;
		logic lt;
	} cmp_t;

	// quotient bits, one per clock
	localparam int DIV_STEPS = 25;

endpackage

// ==== ks_adder.sv ====
module ks_adder (
	input  fp_pkg::sig_t i_a,
	input  fp_pkg::sig_t i_b,
	input  logic         i_cin,
	output fp_pkg::sig_t o_sum,
	output logic         o_cout
);
	import fp_pkg::*;

	// level 0 is bitwise p/g, levels 1 to 5 span 1, 2, 4, 8, 16
	logic [SIG_W-1:0] gl [$clog2(SIG_W)+1];
	logic [SIG_W-1:0] pl [$clog2(SIG_W)+1];

	assign pl[0] = i_a ^ i_b;

	// carry in folded into bit 0 generate
	assign gl[0][0] = (i_a[0] & i_b[0]) | (pl[0][0] & i_cin);

	for (genvar i = 1; i < SIG_W; i++) begin : g_bit
		assign gl[0][i] = i_a[i] & i_b[i];
	end

	for (genvar l = 1; l <= $clog2(SIG_W); l++) begin : g_level
		for (genvar i = 0; i < SIG_W; i++) begin : g_node
			if (i >= (1 << (l - 1))) begin : g_black
				assign gl[l][i] = gl[l-1][i] | (pl[l-1][i] & gl[l-1][i-(1<<(l-1))]);
				assign pl[l][i] = pl[l-1][i] & pl[l-1][i-(1<<(l-1))];
			end else begin : g_pass
				assign gl[l][i] = gl[l-1][i];
				assign pl[l][i] = pl[l-1][i];
			end
		end
	end

	// carry into bit i is the group generate of bits below it
	assign o_sum  = pl[0] ^ {gl[$clog2(SIG_W)][SIG_W-2:0], i_cin};
	assign o_cout = gl[$clog2(SIG_W)][SIG_W-1];

endmodule

// ==== fp_add_sub.sv ====
module fp_add_sub (
	input  fp_pkg::fp_word_t    i_a,
	input  fp_pkg::fp_word_t    i_b,
	input  logic                i_sub,
	output fp_pkg::fp_word_t    o_result,
	output alu_pkg::alu_flags_t o_flags
);
	import fp_pkg::*;
	import alu_pkg::*;

	logic                    sign_b;
	logic                    eff_sub;
	logic                    a_big;
	logic                    sign_res;
	fp_word_t                op_big;
	fp_word_t                op_sml;
	logic [EXP_W-1:0]        exp_diff;
	sig_t                    sig_big;
	sig_t                    sig_sml;
	sig_t                    sig_align;
	sig_t                    add_b;
	sig_t                    sum;
	logic                    cout;
	logic [4:0]              lz;
	sig_t                    sig_norm;
	logic signed [EXP_W+1:0] exp_s;
	logic                    is_zero;

	assign sign_b  = i_b.sign ^ i_sub;
	assign eff_sub = i_a.sign ^ sign_b;

	// magnitude order decides which operand gets aligned
	assign a_big    = {i_a.exp, i_a.frac} >= {i_b.exp, i_b.frac};
	assign op_big   = a_big ? i_a : i_b;
	assign op_sml   = a_big ? i_b : i_a;
	assign sign_res = a_big ? i_a.sign : sign_b;

	assign exp_diff  = op_big.exp - op_sml.exp;
	assign sig_big   = {1'b1, op_big.frac};
	assign sig_sml   = {1'b1, op_sml.frac};
	assign sig_align = sig_sml >> exp_diff;  // 24 and up leaves zero

	// two's complement subtract: invert here, carry in of one
	assign add_b = eff_sub ? ~sig_align : sig_align;

	ks_adder u_ks_adder (
		.i_a   (sig_big),
		.i_b   (add_b),
		.i_cin (eff_sub),
		.o_sum (sum),
		.o_cout(cout)
	);

	// leading one position, highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < SIG_W; i++) begin
			if (sum[i])
				lz = 5'(SIG_W - 1 - i);
		end
	end

	always_comb begin
		if (eff_sub) begin
			sig_norm = sum << lz;
			exp_s    = {2'b00, op_big.exp} - (EXP_W+2)'(lz);
		end else if (cout) begin
			sig_norm = {cout, sum[SIG_W-1:1]};  // carry out, shift right once
			exp_s    = {2'b00, op_big.exp} + (EXP_W+2)'(1);
		end else begin
			sig_norm = sum;
			exp_s    = {2'b00, op_big.exp};
		end
	end

	assign is_zero = eff_sub && (sum == '0);

	always_comb begin
		if (is_zero) begin
			o_result = '0;
		end else begin
			o_result.sign = sign_res;
			o_result.exp  = exp_s[EXP_W-1:0];
			o_result.frac = sig_norm[MAN_W-1:0];
		end
	end

	assign o_flags.ovf = !is_zero && (exp_s > EXP_MAX);
	assign o_flags.unf = !is_zero && (exp_s < 1);
	assign o_flags.dbz = 1'b0;
	assign o_flags.zbz = 1'b0;

endmodule

// ==== fp_mul.sv ====
module fp_mul (
	input  fp_pkg::fp_word_t    i_a,
	input  fp_pkg::fp_word_t    i_b,
	output fp_pkg::fp_word_t    o_result,
	output alu_pkg::alu_flags_t o_flags
);
	import fp_pkg::*;
	import alu_pkg::*;

	sig_t                    sig_a;
	sig_t                    sig_b;
	logic [SIG_W+2:0]        bx;  // multiplier padded for booth triplets
	logic [2*SIG_W-1:0]      pp [SIG_W/2+1];
	logic [2*SIG_W-1:0]      prod;
	logic signed [EXP_W+1:0] exp_s;

	assign sig_a = {1'b1, i_a.frac};
	assign sig_b = {1'b1, i_b.frac};
	assign bx    = {2'b00, sig_b, 1'b0};

	// radix-4 recoding, 13 digits in -2..+2
	always_comb begin
		for (int i = 0; i <= SIG_W/2; i++) begin
			case (bx[2*i +: 3])
				3'b001, 3'b010: pp[i] = {{SIG_W{1'b0}}, sig_a};
				3'b011:         pp[i] = {{(SIG_W-1){1'b0}}, sig_a, 1'b0};
				3'b100:         pp[i] = -{{(SIG_W-1){1'b0}}, sig_a, 1'b0};
				3'b101, 3'b110: pp[i] = -{{SIG_W{1'b0}}, sig_a};
				default:        pp[i] = '0;
			endcase
		end
	end

	always_comb begin
		prod = '0;
		for (int i = 0; i <= SIG_W/2; i++)
			prod = prod + (pp[i] << (2 * i));
	end

	assign exp_s = {2'b00, i_a.exp} + {2'b00, i_b.exp} - (EXP_W+2)'(EXP_BIAS)
		+ (EXP_W+2)'(prod[2*SIG_W-1]);

	assign o_result.sign = i_a.sign ^ i_b.sign;
	assign o_result.exp  = exp_s[EXP_W-1:0];
	assign o_result.frac = prod[2*SIG_W-1] ? prod[2*SIG_W-2 -: MAN_W]
		: prod[2*SIG_W-3 -: MAN_W];

	assign o_flags.ovf = exp_s > EXP_MAX;
	assign o_flags.unf = exp_s < 1;
	assign o_flags.dbz = 1'b0;
	assign o_flags.zbz = 1'b0;

endmodule

// ==== mant_divider.sv ====
module mant_divider (
	input  logic                         clk,
	input  logic                         i_rst_n,
	input  logic                         i_start,
	input  logic                         i_bypass,
	input  fp_pkg::sig_t                 i_x,
	input  fp_pkg::sig_t                 i_y,
	output logic [alu_pkg::DIV_STEPS-1:0] o_q,
	output logic                         o_busy,
	output logic                         o_valid
);
	import fp_pkg::*;
	import alu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} state_e;

	state_e               state;
	logic [SIG_W:0]       rem;      // stays below 2y
	sig_t                 rem_sub;  // below y after the step
	sig_t                 y_q;
	logic [DIV_STEPS-2:0] q_acc;
	logic [4:0]           step;
	logic                 take;

	assign take    = rem >= {1'b0, y_q};
	assign rem_sub = take ? SIG_W'(rem - {1'b0, y_q}) : rem[SIG_W-1:0];

	assign o_busy  = (state == RUN);
	assign o_valid = (state == FINISH);  // one cycle only

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			step  <= '0;
			o_q   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (i_start) begin
						step <= '0;
						if (i_bypass) begin
							o_q   <= '0;
							state <= FINISH;
						end else begin
							state <= RUN;
						end
					end
				end
				RUN: begin
					step <= step + 5'd1;
					if (step == 5'(DIV_STEPS - 1)) begin
						o_q   <= {q_acc, take};  // last bit straight from compare
						state <= FINISH;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// restoring step compares, subtracts and shifts
	always_ff @(posedge clk) begin
		if (state == IDLE && i_start) begin
			rem   <= {1'b0, i_x};
			y_q   <= i_y;
			q_acc <= '0;
		end else if (state == RUN) begin
			rem   <= {rem_sub, 1'b0};
			q_acc <= {q_acc[DIV_STEPS-3:0], take};
		end
	end

endmodule

// ==== fp_div.sv ====
module fp_div (
	input  logic                clk,
	input  logic                i_rst_n,
	input  fp_pkg::fp_word_t    i_a,
	input  fp_pkg::fp_word_t    i_b,
	input  logic                i_start,
	output fp_pkg::fp_word_t    o_result,
	output alu_pkg::alu_flags_t o_flags,
	output logic                o_busy,
	output logic                o_valid
);
	import fp_pkg::*;
	import alu_pkg::*;

	logic                    accept;
	logic                    a_zero;
	logic                    b_zero;
	logic [EXP_W-1:0]        ea_q;
	logic [EXP_W-1:0]        eb_q;
	logic                    sign_q;
	logic                    dbz_q;
	logic                    zbz_q;
	logic [DIV_STEPS-1:0]    q;
	logic signed [EXP_W+1:0] exp_s;

	assign a_zero = (i_a == '0);
	assign b_zero = (i_b == '0);
	assign accept = i_start && !o_busy && !o_valid;  // divider idle

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ea_q   <= '0;
			eb_q   <= '0;
			sign_q <= 1'b0;
			dbz_q  <= 1'b0;
			zbz_q  <= 1'b0;
		end else if (accept) begin
			ea_q   <= i_a.exp;
			eb_q   <= i_b.exp;
			sign_q <= i_a.sign ^ i_b.sign;
			dbz_q  <= b_zero && !a_zero;
			zbz_q  <= b_zero && a_zero;
		end
	end

	mant_divider u_mant_divider (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_start (i_start),
		.i_bypass(b_zero),
		.i_x     ({1'b1, i_a.frac}),
		.i_y     ({1'b1, i_b.frac}),
		.o_q     (q),
		.o_busy  (o_busy),
		.o_valid (o_valid)
	);

	// quotient below one needs one extra step of normalization
	assign exp_s = {2'b00, ea_q} - {2'b00, eb_q} + (EXP_W+2)'(EXP_BIAS)
		- (EXP_W+2)'(!q[DIV_STEPS-1]);

	always_comb begin
		o_flags = '0;
		if (dbz_q || zbz_q) begin
			o_result    = '0;
			o_flags.dbz = dbz_q;
			o_flags.zbz = zbz_q;
		end else begin
			o_result.sign = sign_q;
			o_result.exp  = exp_s[EXP_W-1:0];
			o_result.frac = q[DIV_STEPS-1] ? q[MAN_W:1] : q[MAN_W-1:0];
			o_flags.ovf   = exp_s > EXP_MAX;
			o_flags.unf   = exp_s < 1;
		end
	end

endmodule

// ==== fp_compare.sv ====
module fp_compare (
	input  fp_pkg::fp_word_t i_a,
	input  fp_pkg::fp_word_t i_b,
	output alu_pkg::cmp_t    o_cmp
);
	logic mag_gt;
	logic mag_eq;

	assign mag_gt = {i_a.exp, i_a.frac} > {i_b.exp, i_b.frac};
	assign mag_eq = {i_a.exp, i_a.frac} == {i_b.exp, i_b.frac};

	always_comb begin
		o_cmp = '0;
		if (i_a.sign != i_b.sign) begin
			o_cmp.gt = !i_a.sign;  // positive one wins
			o_cmp.lt = i_a.sign;
		end else if (mag_eq) begin
			o_cmp.eq = 1'b1;
		end else if (mag_gt ^ i_a.sign) begin
			o_cmp.gt = 1'b1;  // order flips for negatives
		end else begin
			o_cmp.lt = 1'b1;
		end
	end

endmodule

// ==== fp_alu_top.sv ====
module fp_alu_top (
	input  logic                clk,
	input  logic                i_rst_n,
	input  fp_pkg::fp_word_t    i_a,
	input  fp_pkg::fp_word_t    i_b,
	input  alu_pkg::alu_op_e    i_op,
	input  logic                i_start,
	output fp_pkg::fp_word_t    o_result,
	output alu_pkg::alu_flags_t o_flags,
	output alu_pkg::cmp_t       o_cmp,
	output logic                o_busy,
	output logic                o_valid
);
	import fp_pkg::*;
	import alu_pkg::*;

	fp_word_t   add_res;
	fp_word_t   mul_res;
	fp_word_t   div_res;
	alu_flags_t add_flags;
	alu_flags_t mul_flags;
	alu_flags_t div_flags;

	fp_add_sub u_add_sub (
		.i_a     (i_a),
		.i_b     (i_b),
		.i_sub   (i_op == OP_SUB),
		.o_result(add_res),
		.o_flags (add_flags)
	);

	fp_mul u_mul (
		.i_a     (i_a),
		.i_b     (i_b),
		.o_result(mul_res),
		.o_flags (mul_flags)
	);

	fp_div u_div (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_a     (i_a),
		.i_b     (i_b),
		.i_start (i_start && (i_op == OP_DIV)),  // other ops never start it
		.o_result(div_res),
		.o_flags (div_flags),
		.o_busy  (o_busy),
		.o_valid (o_valid)
	);

	fp_compare u_compare (
		.i_a  (i_a),
		.i_b  (i_b),
		.o_cmp(o_cmp)
	);

	always_comb begin
		case (i_op)
			OP_MUL: begin
				o_result = mul_res;
				o_flags  = mul_flags;
			end
			OP_DIV: begin
				o_result = div_res;  // held until next accepted start
				o_flags  = div_flags;
			end
			default: begin
				o_result = add_res;
				o_flags  = add_flags;
			end
		endcase
	end

endmodule

// ==== fp_alu_assert.sv ====
module fp_alu_assert (
	input logic          clk,
	input logic          i_rst_n,
	input logic          i_busy,
	input logic          i_valid,
	input alu_pkg::cmp_t i_cmp
);
	timeunit 1ns;
	timeprecision 1ps;

	// divider handshake
	valid_one_cycle: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_valid |=> !i_valid)
		else $error("divider valid held longer than one cycle");

	busy_ends_on_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
		$fell(i_busy) |-> $rose(i_valid))
		else $error("divider busy fell without a valid pulse");

	no_valid_while_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_valid |-> !i_busy ##1 !i_busy)
		else $error("divider busy high with or right after valid");

	cmp_one_hot: assert property (@(posedge clk) disable iff (!i_rst_n)
		$onehot(i_cmp))
		else $error("comparator output not one-hot");

endmodule

// busy and valid come from mant_divider and cmp from fp_compare
bind fp_alu_top fp_alu_assert u_alu_assert (
	.clk    (clk),
	.i_rst_n(i_rst_n),
	.i_busy (o_busy),
	.i_valid(o_valid),
	.i_cmp  (o_cmp)
);

// ==== tb_fp_alu.sv ====
module tb_fp_alu;
	timeunit 1ns;
	timeprecision 1ps;
	import fp_pkg::*;
	import alu_pkg::*;

	localparam int N_ADD    = 300;
	localparam int N_MUL    = 300;
	localparam int N_DIV    = 40;
	localparam int N_ZDIV   = 8;
	localparam int DIV_COST = 27;  // drive edge plus 26 edges to valid
	localparam int LIMIT    = N_ADD + N_MUL + N_DIV * DIV_COST + N_ZDIV * 3 + 200;

	logic       clk;
	logic       i_rst_n;
	fp_word_t   i_a;
	fp_word_t   i_b;
	alu_op_e    i_op;
	logic       i_start;
	fp_word_t   o_result;
	alu_flags_t o_flags;
	cmp_t       o_cmp;
	logic       o_busy;
	logic       o_valid;
	int         errs [5] = '{default: 0};  // add, mul, div, cmp, reset
	int         cycles;

	fp_alu_top i_dut (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_a     (i_a),
		.i_b     (i_b),
		.i_op    (i_op),
		.i_start (i_start),
		.o_result(o_result),
		.o_flags (o_flags),
		.o_cmp   (o_cmp),
		.o_busy  (o_busy),
		.o_valid (o_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] expv,
		input logic [31:0] actv, input int cat);
		assert (expv === actv)
		else begin
			$display("Mismatch %s: expected %08h, actual %08h", name, expv, actv);
			errs[cat]++;
		end
	endtask

	task automatic expect_cond(input logic cond, input string msg, input int cat);
		assert (cond)
		else begin
			$display("Error: %s", msg);
			errs[cat]++;
		end
	endtask

	function automatic fp_word_t rand_word(input int e_lo, input int e_hi);
		fp_word_t w;
		w.sign = 1'($urandom_range(1, 0));
		w.exp  = 8'($urandom_range(e_hi, e_lo));
		w.frac = 23'($urandom);
		return w;
	endfunction

	task automatic add_model(input fp_word_t a, input fp_word_t b, input logic sub,
		output fp_word_t r, output alu_flags_t f);
		logic     sb;
		fp_word_t big;
		fp_word_t sml;
		logic     sign;
		int       shift;
		int       sig_s;
		int       sum;
		int       e;
		sb = b.sign ^ sub;
		r  = '0;
		f  = '0;
		if ({a.exp, a.frac} >= {b.exp, b.frac}) begin
			big  = a;
			sml  = b;
			sign = a.sign;
		end else begin
			big  = b;
			sml  = a;
			sign = sb;
		end
		shift = int'(big.exp) - int'(sml.exp);
		sig_s = (shift > 24) ? 0 : int'({1'b1, sml.frac}) >> shift;
		e     = int'(big.exp);
		if (a.sign == sb) begin
			sum = int'({1'b1, big.frac}) + sig_s;
			if (sum >= (1 << 24)) begin
				sum = sum >> 1;
				e   = e + 1;
			end
		end else begin
			sum = int'({1'b1, big.frac}) - sig_s;
			if (sum == 0)
				return;  // exact cancellation
			while (sum < (1 << 23)) begin
				sum = sum << 1;
				e   = e - 1;
			end
		end
		r.sign = sign;
		r.exp  = e[7:0];
		r.frac = sum[22:0];
		f.ovf  = e > 254;
		f.unf  = e < 1;
	endtask

	task automatic mul_model(input fp_word_t a, input fp_word_t b,
		output fp_word_t r, output alu_flags_t f);
		logic [47:0] p;
		int          e;
		p = {1'b1, a.frac} * {1'b1, b.frac};
		e = int'(a.exp) + int'(b.exp) - 127;
		if (p[47]) begin
			r.frac = p[46:24];
			e      = e + 1;
		end else begin
			r.frac = p[45:23];
		end
		r.sign = a.sign ^ b.sign;
		r.exp  = e[7:0];
		f      = '0;
		f.ovf  = e > 254;
		f.unf  = e < 1;
	endtask

	task automatic div_model(input fp_word_t a, input fp_word_t b,
		output fp_word_t r, output alu_flags_t f);
		logic [47:0] num;
		logic [24:0] q;
		int          e;
		num = {1'b1, a.frac, 24'h0};
		q   = num / {1'b1, b.frac};
		e   = int'(a.exp) - int'(b.exp) + 127;
		if (q[24]) begin
			r.frac = q[23:1];
		end else begin
			r.frac = q[22:0];
			e      = e - 1;
		end
		r.sign = a.sign ^ b.sign;
		r.exp  = e[7:0];
		f      = '0;
		f.ovf  = e > 254;
		f.unf  = e < 1;
	endtask

	function automatic cmp_t cmp_model(input fp_word_t a, input fp_word_t b);
		cmp_t        c;
		logic [30:0] ma;
		logic [30:0] mb;
		ma = {a.exp, a.frac};
		mb = {b.exp, b.frac};
		c  = '0;
		if (a.sign != b.sign) begin
			c.gt = !a.sign;
			c.lt = a.sign;
		end else if (ma == mb) begin
			c.eq = 1'b1;
		end else if (!a.sign) begin
			c.gt = ma > mb;
			c.lt = ma < mb;
		end else begin
			c.gt = ma < mb;  // negatives
			c.lt = ma > mb;
		end
		return c;
	endfunction

	task automatic apply_vec(input fp_word_t a, input fp_word_t b, input alu_op_e op);
		@(posedge clk);
		i_a  <= a;
		i_b  <= b;
		i_op <= op;
		@(negedge clk);
	endtask

	task automatic run_div(input fp_word_t a, input fp_word_t b, input string name);
		fp_word_t   exp_r;
		alu_flags_t exp_f;
		int         want;
		int         edges;
		logic       got;
		if (b == '0) begin
			exp_r = '0;
			exp_f = '0;
			exp_f.zbz = (a == '0);
			exp_f.dbz = (a != '0);
			want = 1;
		end else begin
			div_model(a, b, exp_r, exp_f);
			want = 26;
		end
		@(posedge clk);
		i_a     <= a;
		i_b     <= b;
		i_op    <= OP_DIV;
		i_start <= 1'b1;
		@(posedge clk);  // start edge
		i_start <= 1'b0;
		edges = 1;
		got   = 1'b0;
		while (!got && edges <= 30) begin
			@(negedge clk);
			if (o_valid) begin
				got = 1'b1;
			end else begin
				expect_cond(o_busy == (want == 26), {name, ": busy level wrong before valid"}, 2);
				@(posedge clk);
				edges++;
			end
		end
		expect_cond(got, {name, ": no valid pulse from the divider"}, 2);
		expect_cond(!o_busy, {name, ": busy still high with valid"}, 2);
		check_value({name, " latency"}, want, edges, 2);
		check_value({name, " flags"}, exp_f, o_flags, 2);
		check_value({name, " result"}, exp_r, o_result, 2);
	endtask

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Error: run did not finish within %0d cycles", LIMIT);
		$display("tests failed");
		$finish;
	end

	initial begin
		fp_word_t   a;
		fp_word_t   b;
		fp_word_t   exp_r;
		alu_flags_t exp_f;
		alu_op_e    op;
		int         d;
		int         total;
		void'($urandom(18));
		i_rst_n = 1'b0;
		i_a     = '0;
		i_b     = '0;
		i_op    = OP_DIV;  // reset check reads the divide flags
		i_start = 1'b0;
		repeat (2) @(posedge clk);
		i_rst_n <= 1'b1;
		@(negedge clk);
		expect_cond(!o_busy && !o_valid, "busy or valid high after reset", 4);
		check_value("reset divide flags", '0, o_flags, 4);

		for (int i = 0; i < N_ADD; i++) begin
			a  = rand_word(1, 254);
			b  = rand_word(1, 254);
			op = ($urandom_range(1, 0) == 1) ? OP_SUB : OP_ADD;
			if (i % 10 == 0) begin
				b  = a;
				op = OP_SUB;
			end else if (i % 3 == 0) begin
				d     = int'(a.exp) + int'($urandom_range(6, 0)) - 3;  // close exponents
				b.exp = 8'((d < 1) ? 1 : (d > 254) ? 254 : d);
			end
			apply_vec(a, b, op);
			add_model(a, b, op == OP_SUB, exp_r, exp_f);
			check_value($sformatf("add %0d flags", i), exp_f, o_flags, 0);
			if (exp_f == '0)
				check_value($sformatf("add %0d result", i), exp_r, o_result, 0);
			check_value($sformatf("add %0d cmp", i), cmp_model(a, b), o_cmp, 3);
		end

		for (int i = 0; i < N_MUL; i++) begin
			if (i % 5 == 3) begin
				a = rand_word(190, 254);  // overflow side
				b = rand_word(190, 254);
			end else if (i % 5 == 4) begin
				a = rand_word(1, 60);
				b = rand_word(1, 60);
			end else begin
				a = rand_word(1, 254);
				b = rand_word(1, 254);
			end
			apply_vec(a, b, OP_MUL);
			mul_model(a, b, exp_r, exp_f);
			check_value($sformatf("mul %0d flags", i), exp_f, o_flags, 1);
			check_value($sformatf("mul %0d result", i), exp_r, o_result, 1);
			check_value($sformatf("mul %0d cmp", i), cmp_model(a, b), o_cmp, 3);
		end

		for (int i = 0; i < N_DIV; i++)
			run_div(rand_word(1, 254), rand_word(1, 254), $sformatf("div %0d", i));
		for (int i = 0; i < N_ZDIV; i++) begin
			a = (i % 2 == 1) ? fp_word_t'('0) : rand_word(1, 254);
			run_div(a, '0, $sformatf("zero div %0d", i));
		end

		total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
		$display("errors: add %0d, mul %0d, div %0d, cmp %0d, reset %0d, total %0d",
			errs[0], errs[1], errs[2], errs[3], errs[4], total);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== sim.f ====
fp_pkg.sv
alu_pkg.sv
ks_adder.sv
fp_add_sub.sv
fp_mul.sv
mant_divider.sv
fp_div.sv
fp_compare.sv
fp_alu_top.sv
fp_alu_assert.sv
tb_fp_alu.sv
